/* include/hazard_params.svh */
// Parameter macros for the hazard unit: register index width, data-segment register, counter width
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Register file index width
// 16 architectural registers
`define HZ_REG_W 4

// Register substituted for rs on data-segment accesses
// Fixed by the ISA as r14
`define HZ_DATA_SEG_REG 14

// Width of each stall statistics counter
// Counters saturate at all ones
`define HZ_CNT_W 16

`endif

/* src/hazard_pkg.sv */
// Package with the opcode and FSM state enums and the decode, destination and counter structs
package hazard_pkg;

    `include "hazard_params.svh"

    // Instruction class as seen by the hazard logic
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_CALL,
        OP_RET
    } op_e;

    // Redirect FSM states
    typedef enum logic {
        RS_IDLE,
        RS_WAIT
    } redirect_state_e;

    // Instruction held in IF/ID
    typedef struct packed {
        logic                 valid;
        op_e                  op;
        logic [`HZ_REG_W-1:0] rs;
        logic [`HZ_REG_W-1:0] rt;
        logic [`HZ_REG_W-1:0] rd;
        // Instruction writes rd at write-back
        logic                 writes_rd;
        // Use data-segment register in place of rs
        logic                 data_seg;
    } decode_t;

    // One pending write-back destination
    typedef struct packed {
        logic                 valid;
        logic [`HZ_REG_W-1:0] rd;
    } dest_t;

    // Pending destinations of the three in-flight stages
    typedef struct packed {
        dest_t id_ex;
        dest_t ex_mem;
        dest_t mem_wb;
    } stage_dests_t;

    // Stall statistics
    typedef struct packed {
        logic [`HZ_CNT_W-1:0] data_cycles;
        logic [`HZ_CNT_W-1:0] redirect_cycles;
    } stall_counts_t;

endpackage

/* src/dest_tracker.sv */
// Shift chain of pending destination registers for ID/EX, EX/MEM and MEM/WB
`timescale 1ns/1ps

module dest_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  hazard_pkg::decode_t     decode,
    input  logic                    issue,
    output hazard_pkg::stage_dests_t dests
);

    // Destination entering ID/EX this cycle
    hazard_pkg::dest_t entry;

    // Bubble unless the instruction actually issues and writes a register
    always_comb begin
        entry.valid = issue && decode.writes_rd;
        entry.rd    = decode.rd;
    end

    // Valid bits are the control state
    always_ff @(posedge clk) begin
        if (rst) begin
            dests.id_ex.valid  <= 1'b0;
            dests.ex_mem.valid <= 1'b0;
            dests.mem_wb.valid <= 1'b0;
        end else begin
            // Chain moves every cycle, stalls included
            dests.id_ex.valid  <= entry.valid;
            dests.ex_mem.valid <= dests.id_ex.valid;
            dests.mem_wb.valid <= dests.ex_mem.valid;
        end
    end

    // Register indices follow along
    // Only meaningful when the matching valid is set
    always_ff @(posedge clk) begin
        dests.id_ex.rd  <= entry.rd;
        dests.ex_mem.rd <= dests.id_ex.rd;
        dests.mem_wb.rd <= dests.ex_mem.rd;
    end

endmodule

/* src/hazard_compare.sv */
// Read-after-write compare of the decoded register fields against pending destinations
`timescale 1ns/1ps

`include "hazard_params.svh"

module hazard_compare (
    input  hazard_pkg::decode_t      decode,
    input  hazard_pkg::stage_dests_t dests,
    output logic                     raw_match
);

    // First read register after data-segment substitution
    logic [`HZ_REG_W-1:0] read_reg_1;

    // Per-stage match results
    logic id_ex_hit;
    logic ex_mem_hit;
    logic mem_wb_hit;

    // Any of the three fields equals a valid destination
    function automatic logic stage_hit(
        input hazard_pkg::dest_t    dest,
        input logic [`HZ_REG_W-1:0] r1,
        input logic [`HZ_REG_W-1:0] r2,
        input logic [`HZ_REG_W-1:0] r3
    );
        logic eq_any;
        eq_any = (r1 == dest.rd) || (r2 == dest.rd) || (r3 == dest.rd);
        return dest.valid && eq_any;
    endfunction

    // Data-segment accesses read r14 through the first port
    always_comb begin
        if (decode.data_seg) begin
            read_reg_1 = `HZ_REG_W'(`HZ_DATA_SEG_REG);
        end else begin
            read_reg_1 = decode.rs;
        end
    end

    // rd counts too, it may be read as a store source
    assign id_ex_hit  = stage_hit(dests.id_ex, read_reg_1, decode.rt, decode.rd);
    assign ex_mem_hit = stage_hit(dests.ex_mem, read_reg_1, decode.rt, decode.rd);
    assign mem_wb_hit = stage_hit(dests.mem_wb, read_reg_1, decode.rt, decode.rd);

    // Opcode and valid qualification happen in the FSM
    assign raw_match = id_ex_hit || ex_mem_hit || mem_wb_hit;

endmodule

/* src/redirect_fsm.sv */
// Issue control FSM for data stalls and call/return PC hazards
`timescale 1ns/1ps

module redirect_fsm (
    input  logic                clk,
    input  logic                rst,
    input  hazard_pkg::decode_t decode,
    input  logic                raw_match,
    input  logic                pc_update,
    output logic                issue,
    output logic                data_hazard,
    output logic                pc_hazard
);

    hazard_pkg::redirect_state_e state_q;
    hazard_pkg::redirect_state_e state_d;

    // Decoded call or return
    logic is_redirect;
    // Valid decode seen while idle
    logic idle_valid;

    assign is_redirect = (decode.op == hazard_pkg::OP_CALL) ||
                         (decode.op == hazard_pkg::OP_RET);
    assign idle_valid  = decode.valid && (state_q == hazard_pkg::RS_IDLE);

    // Calls and returns never stall on data
    assign data_hazard = idle_valid && !is_redirect && raw_match;

    // Nothing issues while waiting for the PC
    assign issue = idle_valid && !data_hazard;

    // Hold the front end from decode of call/ret until the update pulse
    always_comb begin
        if (state_q == hazard_pkg::RS_WAIT) begin
            pc_hazard = !pc_update;
        end else begin
            pc_hazard = idle_valid && is_redirect;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            hazard_pkg::RS_IDLE: begin
                // Call/ret issues now, then wait
                if (idle_valid && is_redirect) begin
                    state_d = hazard_pkg::RS_WAIT;
                end
            end
            hazard_pkg::RS_WAIT: begin
                // Decode ignored here
                if (pc_update) begin
                    state_d = hazard_pkg::RS_IDLE;
                end
            end
            default: state_d = hazard_pkg::RS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= hazard_pkg::RS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* src/stall_counter.sv */
// Saturating counters of data-stall and redirect-wait cycles
`timescale 1ns/1ps

`include "hazard_params.svh"

module stall_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      data_hazard,
    input  logic                      pc_hazard,
    output hazard_pkg::stall_counts_t counts
);

    // Next counter values
    hazard_pkg::stall_counts_t counts_d;

    // Increment unless already at all ones
    function automatic logic [`HZ_CNT_W-1:0] sat_inc(
        input logic [`HZ_CNT_W-1:0] value,
        input logic                 en
    );
        logic at_max;
        at_max = &value;
        if (en && !at_max) begin
            return value + `HZ_CNT_W'(1);
        end
        return value;
    endfunction

    always_comb begin
        counts_d.data_cycles     = sat_inc(counts.data_cycles, data_hazard);
        counts_d.redirect_cycles = sat_inc(counts.redirect_cycles, pc_hazard);
    end

    // Counts land one cycle after the hazard cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            counts <= counts_d;
        end
    end

endmodule

/* src/hazard_unit.sv */
// Top level of the hazard detection and issue control block
`timescale 1ns/1ps

module hazard_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  hazard_pkg::decode_t       decode,
    input  logic                      pc_update,
    output logic                      data_hazard,
    output logic                      pc_hazard,
    output hazard_pkg::stall_counts_t counts
);

    // Pending write-back destinations
    hazard_pkg::stage_dests_t dests;
    // Unqualified register match
    logic raw_match;
    // Instruction leaves IF/ID this cycle
    logic issue;

    dest_tracker u_dest_tracker (
        .clk    (clk),
        .rst    (rst),
        .decode (decode),
        .issue  (issue),
        .dests  (dests)
    );

    hazard_compare u_hazard_compare (
        .decode    (decode),
        .dests     (dests),
        .raw_match (raw_match)
    );

    redirect_fsm u_redirect_fsm (
        .clk         (clk),
        .rst         (rst),
        .decode      (decode),
        .raw_match   (raw_match),
        .pc_update   (pc_update),
        .issue       (issue),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    // Statistics only observe the hazards
    stall_counter u_stall_counter (
        .clk         (clk),
        .rst         (rst),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard),
        .counts      (counts)
    );

endmodule

/* test/hazard_unit_assert.sv */
// Concurrent assertions on the hazard outputs, bound to the hazard unit top level
`timescale 1ns/1ps

module hazard_unit_assert (
    input logic                        clk,
    input logic                        rst,
    input logic                        pc_update,
    input logic                        data_hazard,
    input logic                        pc_hazard,
    input hazard_pkg::redirect_state_e state
);

    // A stall is data or redirect, never both
    a_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(data_hazard && pc_hazard))
        else $error("data_hazard and pc_hazard high in the same cycle");

    // First cycle out of reset
    a_reset_clear: assert property (@(posedge clk)
        $fell(rst) |-> !data_hazard && !pc_hazard)
        else $error("hazard high in the first cycle after reset");

    // Update pulse drops the hold in its own cycle
    a_update_release: assert property (@(posedge clk) disable iff (rst)
        (pc_update && state == hazard_pkg::RS_WAIT) |-> !pc_hazard)
        else $error("pc_hazard high during the PC update cycle");

endmodule

bind hazard_unit hazard_unit_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .pc_update   (pc_update),
    .data_hazard (data_hazard),
    .pc_hazard   (pc_hazard),
    .state       (u_redirect_fsm.state_q)
);

/* test/hazard_unit_tb.sv */
// Hazard unit testbench with stimulus, reference model, per-cycle checker and timeout
`timescale 1ns/1ps

`include "hazard_params.svh"

module hazard_unit_tb;

    localparam int RANDOM_CYCLES = 2000;
    // About 200 directed cycles, the random stream, and margin
    localparam int MAX_CYCLES = 200 + RANDOM_CYCLES + 800;
    localparam int CNT_MAX = (1 << `HZ_CNT_W) - 1;

    logic clk = 1'b0;
    logic rst;
    hazard_pkg::decode_t decode;
    logic pc_update;
    logic data_hazard;
    logic pc_hazard;
    hazard_pkg::stall_counts_t counts;

    // Model of the pending destinations with ID/EX at index 0
    logic [2:0] m_valid;
    logic [`HZ_REG_W-1:0] m_rd [3];
    // Model is waiting for the PC update
    logic m_wait;
    int m_data_cnt;
    int m_redir_cnt;

    int checks = 0;
    int errors = 0;
    int test_base = 0;
    int cycles = 0;

    hazard_unit dut (
        .clk         (clk),
        .rst         (rst),
        .decode      (decode),
        .pc_update   (pc_update),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard),
        .counts      (counts)
    );

    always #10 clk = ~clk;

    // Expected {data_hazard, pc_hazard} for this decode and model state
    function automatic logic [1:0] expected_hazards(input hazard_pkg::decode_t d, input logic upd);
        logic [`HZ_REG_W-1:0] reads [3];
        logic redirect;
        logic hit;
        int s;
        int r;
        reads[0] = d.data_seg ? `HZ_REG_W'(`HZ_DATA_SEG_REG) : d.rs;
        reads[1] = d.rt;
        reads[2] = d.rd;
        redirect = d.op inside {hazard_pkg::OP_CALL, hazard_pkg::OP_RET};
        hit = 1'b0;
        for (s = 0; s < 3; s++) begin
            for (r = 0; r < 3; r++) begin
                hit = hit || (m_valid[s] && (m_rd[s] == reads[r]));
            end
        end
        // Decode ignored while waiting for the update pulse
        if (m_wait) begin
            return {1'b0, !upd};
        end
        return {d.valid && !redirect && hit, d.valid && redirect};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic hazard_pkg::decode_t make_instr(input hazard_pkg::op_e op, input int rs,
            input int rt, input int rd, input int wr, input int ds);
        hazard_pkg::decode_t d;
        d.valid     = 1'b1;
        d.op        = op;
        d.rs        = `HZ_REG_W'(rs);
        d.rt        = `HZ_REG_W'(rt);
        d.rd        = `HZ_REG_W'(rd);
        d.writes_rd = 1'(wr);
        d.data_seg  = 1'(ds);
        return d;
    endfunction

    // Present one instruction, hold it through data stalls, count them
    task automatic send_instr(input hazard_pkg::decode_t d, output int n);
        @(posedge clk);
        decode    <= d;
        pc_update <= 1'b0;
        n = 0;
        @(negedge clk);
        while (data_hazard) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            decode    <= '0;
            pc_update <= 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // Call or return behind a matching producer, then the update pulse
    task automatic run_redirect(input hazard_pkg::op_e op);
        int n;
        send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 5, 1, 0), n);
        @(posedge clk);
        decode <= make_instr(op, 5, 5, 5, 1, 0);
        @(negedge clk);
        check_eq("pc_hazard", 32'(1), 32'(pc_hazard));
        check_eq("data_hazard", 32'(0), 32'(data_hazard));
        // Valid decode during the wait must not issue
        @(posedge clk);
        decode <= make_instr(hazard_pkg::OP_ALU, 5, 5, 9, 1, 0);
        repeat (4) begin
            @(negedge clk);
            check_eq("pc_hazard", 32'(1), 32'(pc_hazard));
        end
        @(posedge clk);
        decode    <= '0;
        pc_update <= 1'b1;
        @(negedge clk);
        check_eq("pc_hazard", 32'(0), 32'(pc_hazard));
        // r9 never entered the tracker
        send_instr(make_instr(hazard_pkg::OP_ALU, 9, 9, 10, 1, 0), n);
        check_eq("data_hazard cycles", 32'(0), n);
        idle_cycles(4);
    endtask

    // Compare on the falling edge, then advance the model to the next state
    always @(negedge clk) begin
        logic [1:0] expect_hz;
        if (rst) begin
            m_valid     = '0;
            m_wait      = 1'b0;
            m_data_cnt  = 0;
            m_redir_cnt = 0;
        end else begin
            expect_hz = expected_hazards(decode, pc_update);
            check_eq("data_hazard", 32'(expect_hz[1]), 32'(data_hazard));
            check_eq("pc_hazard", 32'(expect_hz[0]), 32'(pc_hazard));
            check_eq("counts.data_cycles", m_data_cnt, 32'(counts.data_cycles));
            check_eq("counts.redirect_cycles", m_redir_cnt, 32'(counts.redirect_cycles));
            m_valid = {m_valid[1:0],
                       decode.valid && !m_wait && !expect_hz[1] && decode.writes_rd};
            m_rd[2] = m_rd[1];
            m_rd[1] = m_rd[0];
            m_rd[0] = decode.rd;
            if (m_wait) begin
                m_wait = !pc_update;
            end else begin
                m_wait = decode.valid && (decode.op inside {hazard_pkg::OP_CALL,
                                                            hazard_pkg::OP_RET});
            end
            if (expect_hz[1] && m_data_cnt < CNT_MAX) begin
                m_data_cnt++;
            end
            if (expect_hz[0] && m_redir_cnt < CNT_MAX) begin
                m_redir_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        hazard_pkg::decode_t rnd;
        logic held;
        int stalls;
        int gap;
        int k;
        int f;
        void'($urandom(32'h31a82be0));
        rst       = 1'b1;
        decode    = '0;
        pc_update = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("data_hazard", 32'(0), 32'(data_hazard));
        check_eq("pc_hazard", 32'(0), 32'(pc_hazard));
        check_eq("counts", 32'(0), counts);
        end_test("reset");

        // Producer of r5, then a reader of r5 through rs after 0 to 3 fillers
        for (gap = 0; gap < 4; gap++) begin
            send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 5, 1, 0), stalls);
            for (k = 0; k < gap; k++) begin
                send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 8 + k, 1, 0), stalls);
            end
            send_instr(make_instr(hazard_pkg::OP_LOAD, 5, 3, 6, 1, 0), stalls);
            check_eq("data_hazard cycles", 3 - gap, stalls);
            idle_cycles(4);
        end
        // Dependence through rs, rt and rd in turn
        for (f = 0; f < 3; f++) begin
            send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 5, 1, 0), stalls);
            send_instr(make_instr(hazard_pkg::OP_STORE, f == 0 ? 5 : 3, f == 1 ? 5 : 4,
                                  f == 2 ? 5 : 6, 0, 0), stalls);
            check_eq("data_hazard cycles", 3, stalls);
            idle_cycles(4);
        end
        // No register written, then a plain mismatch
        send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 5, 0, 0), stalls);
        send_instr(make_instr(hazard_pkg::OP_ALU, 5, 5, 5, 1, 0), stalls);
        check_eq("data_hazard cycles", 0, stalls);
        send_instr(make_instr(hazard_pkg::OP_ALU, 6, 7, 8, 1, 0), stalls);
        check_eq("data_hazard cycles", 0, stalls);
        idle_cycles(4);
        end_test("raw_stall");

        // r14 producer stalls a data-segment access, an rs producer does not
        send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 14, 1, 0), stalls);
        send_instr(make_instr(hazard_pkg::OP_LOAD, 3, 4, 6, 1, 1), stalls);
        check_eq("data_hazard cycles", 3, stalls);
        idle_cycles(4);
        send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 3, 1, 0), stalls);
        send_instr(make_instr(hazard_pkg::OP_LOAD, 3, 4, 6, 1, 1), stalls);
        check_eq("data_hazard cycles", 0, stalls);
        idle_cycles(4);
        end_test("data_segment");

        run_redirect(hazard_pkg::OP_CALL);
        run_redirect(hazard_pkg::OP_RET);
        // Update pulse while idle changes nothing
        @(posedge clk);
        pc_update <= 1'b1;
        @(negedge clk);
        check_eq("pc_hazard", 32'(0), 32'(pc_hazard));
        send_instr(make_instr(hazard_pkg::OP_ALU, 1, 2, 3, 1, 0), stalls);
        check_eq("data_hazard cycles", 0, stalls);
        check_eq("pc_hazard", 32'(0), 32'(pc_hazard));
        idle_cycles(4);
        end_test("call_return");

        // Model sums hold still while decode is idle
        idle_cycles(2);
        @(negedge clk);
        check_eq("counts.data_cycles", m_data_cnt, 32'(counts.data_cycles));
        check_eq("counts.redirect_cycles", m_redir_cnt, 32'(counts.redirect_cycles));
        end_test("statistics");

        // One cycle per pass, decode held while either hazard is high
        for (k = 0; k < RANDOM_CYCLES; k++) begin
            @(negedge clk);
            held = data_hazard || pc_hazard;
            rnd = make_instr(hazard_pkg::op_e'($urandom_range(0, 6)), $urandom_range(0, 15),
                             $urandom_range(0, 15), $urandom_range(0, 15),
                             $urandom_range(0, 1), $urandom_range(0, 3) == 0);
            rnd.valid = $urandom_range(0, 3) != 0;
            @(posedge clk);
            if (!held) begin
                decode <= rnd;
            end
            pc_update <= $urandom_range(0, 7) == 0;
        end
        idle_cycles(2);
        @(negedge clk);
        end_test("random");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
src/hazard_pkg.sv
src/dest_tracker.sv
src/hazard_compare.sv
src/redirect_fsm.sv
src/stall_counter.sv
src/hazard_unit.sv
test/hazard_unit_assert.sv
test/hazard_unit_tb.sv

/* Bender.yml */
package:
  name: hazard_unit

export_include_dirs:
  - include

sources:
  - files:
      - src/hazard_pkg.sv
      - src/dest_tracker.sv
      - src/hazard_compare.sv
      - src/redirect_fsm.sv
      - src/stall_counter.sv
      - src/hazard_unit.sv
  - target: test
    files:
      - test/hazard_unit_assert.sv
      - test/hazard_unit_tb.sv
